// ==== build.f ====
design/sd_pkg.sv
design/sd_wb_regs.sv
design/sd_cmd_ctrl.sv
design/sd_cmd_phy.sv
design/sd_ctrl_top.sv
test/tb_sd_card_model.sv
test/tb_sd_ctrl.sv

// ==== design/sd_cmd_ctrl.sv ====
module sd_cmd_ctrl import sd_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        arst_n_i,
  input  cmd_req_t    cmd_req_i,
  input  logic        cmd_launch_i,
  output line_req_t   line_req_o,
  output logic        line_valid_o,
  input  logic        line_accept_i,
  input  line_rsp_t   line_rsp_i,
  input  logic        line_done_i,
  output cmd_result_t result_o,
  output logic        result_done_o
);

  cmd_req_t req_q;       // Command held for the whole transaction
  logic     pending_q;   // Launch seen, result not yet back
  logic     rsp_exp;
  logic     idx_ok;
  logic     crc_bad;

  assign rsp_exp = (req_q.rsp != RSP_NONE);  // Codes 2, 3 count as 48-bit

  // Token body: start 0, transmission 1, index, argument
  assign line_req_o = '{
    token:      {1'b0, 1'b1, req_q.index, req_q.arg},
    expect_rsp: rsp_exp,
    timeout:    req_q.timeout
  };

  ////////////////////////////////////////////////////////////////////////
  // Response checks
  ////////////////////////////////////////////////////////////////////////
  assign idx_ok  = (line_rsp_i.token[CMD_TOKEN_W-3 -: CMD_IDX_W] == req_q.index);
  assign crc_bad = ~line_rsp_i.crc_ok;

  always_ff @(posedge wb_clk_i) begin
    if (cmd_launch_i) req_q <= cmd_req_i;
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q     <= 1'b0;
      line_valid_o  <= 1'b0;
      result_done_o <= 1'b0;
    end else begin
      result_done_o <= 1'b0;
      if (cmd_launch_i) begin
        pending_q    <= 1'b1;
        line_valid_o <= 1'b1;                 // Held until the phy accepts
      end
      if (line_valid_o && line_accept_i) line_valid_o <= 1'b0;
      if (line_done_i) begin
        pending_q     <= 1'b0;
        result_done_o <= 1'b1;
      end
    end
  end

  // Result payload, only meaningful with result_done_o
  always_ff @(posedge wb_clk_i) begin
    if (line_done_i) begin
      result_o.resp_arg    <= rsp_exp ? line_rsp_i.token[CRC7_W+1 +: 32] : '0;
      result_o.done        <= 1'b1;
      result_o.timeout_err <= rsp_exp & line_rsp_i.timed_out;
      result_o.crc_err     <= rsp_exp & ~line_rsp_i.timed_out & req_q.crc_chk & crc_bad;
      result_o.index_err   <= rsp_exp & ~line_rsp_i.timed_out & req_q.idx_chk & ~idx_ok;
    end
  end

  // Register file busy bit must keep launches apart
  a_no_launch_pending: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    cmd_launch_i |-> !pending_q)
    else $error("command launched while one is pending");

endmodule

// ==== design/sd_cmd_phy.sv ====
module sd_cmd_phy import sd_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       arst_n_i,
  input  logic [7:0] clk_div_i,
  input  line_req_t  line_req_i,
  input  logic       line_valid_i,
  output logic       line_accept_o,
  output line_rsp_t  line_rsp_o,
  output logic       line_done_o,
  output logic       sd_clk_o,
  input  logic       sd_cmd_i,
  output logic       sd_cmd_o,
  output logic       sd_cmd_oe_o
);

  phy_state_e state_q;

  logic [7:0]             div_cnt_q;
  logic                   sd_clk_q;
  logic                   tick;       // SD clock toggles this cycle
  logic                   rise_en;
  logic                   fall_en;

  logic [5:0]             bit_cnt_q;  // Position in the 48-bit token
  logic [CMD_BODY_W-1:0]  tx_sh_q;
  logic [CMD_TOKEN_W-1:0] rx_sh_q;
  logic [CRC7_W-1:0]      crc_q;
  logic [15:0]            tmo_cnt_q;
  logic [15:0]            tmo_lim_q;
  logic                   expect_q;
  logic                   timed_out_q;

  ////////////////////////////////////////////////////////////////////////
  // SD clock divider
  ////////////////////////////////////////////////////////////////////////
  assign tick    = (div_cnt_q >= clk_div_i);  // >= copes with a divider change
  assign rise_en = tick & ~sd_clk_q;
  assign fall_en = tick & sd_clk_q;

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_cnt_q <= '0;
      sd_clk_q  <= 1'b0;
    end else if (tick) begin
      div_cnt_q <= '0;
      sd_clk_q  <= ~sd_clk_q;
    end else begin
      div_cnt_q <= div_cnt_q + 8'd1;
    end
  end

  assign sd_clk_o = sd_clk_q;

  ////////////////////////////////////////////////////////////////////////
  // Line FSM
  ////////////////////////////////////////////////////////////////////////
  assign line_accept_o = (state_q == IDLE) & line_valid_i;

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= IDLE;
      sd_cmd_o    <= 1'b1;                  // Line idles high
      sd_cmd_oe_o <= 1'b0;
      bit_cnt_q   <= '0;
      tx_sh_q     <= '0;
      rx_sh_q     <= '0;
      crc_q       <= '0;
      tmo_cnt_q   <= '0;
      tmo_lim_q   <= '0;
      expect_q    <= 1'b0;
      timed_out_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: if (line_valid_i) begin
          tx_sh_q     <= line_req_i.token;
          expect_q    <= line_req_i.expect_rsp;
          tmo_lim_q   <= line_req_i.timeout;
          bit_cnt_q   <= '0;
          crc_q       <= '0;
          timed_out_q <= 1'b0;
          state_q     <= SEND;
        end
        SEND: if (fall_en) begin            // Drive on falling SD edge
          sd_cmd_oe_o <= 1'b1;
          bit_cnt_q   <= bit_cnt_q + 6'd1;
          if (bit_cnt_q < 6'(CMD_BODY_W)) begin
            sd_cmd_o <= tx_sh_q[CMD_BODY_W-1];
            tx_sh_q  <= {tx_sh_q[CMD_BODY_W-2:0], 1'b0};
            crc_q    <= crc7_next(crc_q, tx_sh_q[CMD_BODY_W-1]);
          end else if (bit_cnt_q < 6'(CMD_TOKEN_W - 1)) begin
            sd_cmd_o <= crc_q[CRC7_W-1];    // CRC MSB first
            crc_q    <= {crc_q[CRC7_W-2:0], 1'b0};
          end else if (bit_cnt_q == 6'(CMD_TOKEN_W - 1)) begin
            sd_cmd_o <= 1'b1;               // End bit
          end else begin                    // Release after the end bit
            sd_cmd_oe_o <= 1'b0;
            sd_cmd_o    <= 1'b1;
            bit_cnt_q   <= '0;
            crc_q       <= '0;
            tmo_cnt_q   <= '0;
            state_q     <= expect_q ? WAIT_START : DONE;
          end
        end
        WAIT_START: if (rise_en) begin
          if (!sd_cmd_i) begin              // Start bit found
            rx_sh_q   <= {rx_sh_q[CMD_TOKEN_W-2:0], sd_cmd_i};
            crc_q     <= crc7_next(crc_q, sd_cmd_i);
            bit_cnt_q <= 6'd1;
            state_q   <= RECV;
          end else if (tmo_cnt_q == tmo_lim_q) begin
            timed_out_q <= 1'b1;
            state_q     <= DONE;
          end else begin
            tmo_cnt_q <= tmo_cnt_q + 16'd1;
          end
        end
        RECV: if (rise_en) begin            // Sample on rising SD edge
          rx_sh_q   <= {rx_sh_q[CMD_TOKEN_W-2:0], sd_cmd_i};
          bit_cnt_q <= bit_cnt_q + 6'd1;
          if (bit_cnt_q < 6'(CMD_BODY_W)) crc_q <= crc7_next(crc_q, sd_cmd_i);
          if (bit_cnt_q == 6'(CMD_TOKEN_W - 1)) state_q <= DONE;
        end
        DONE:    state_q <= IDLE;           // One-cycle done pulse
        default: state_q <= IDLE;
      endcase
    end
  end

  assign line_done_o = (state_q == DONE);
  assign line_rsp_o  = '{
    token:     rx_sh_q,
    timed_out: timed_out_q,
    crc_ok:    (rx_sh_q[1 +: CRC7_W] == crc_q)
  };

  // Card owns the line from command end until response end
  a_oe_released: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    (state_q inside {WAIT_START, RECV}) |-> !sd_cmd_oe_o)
    else $error("CMD driven while waiting for the card");

endmodule

// ==== design/sd_ctrl_top.sv ====
module sd_ctrl_top import sd_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             arst_n_i,
  // Wishbone slave
  input  logic [WB_AW-1:0] wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  output logic [WB_DW-1:0] wb_dat_o,
  input  logic [3:0]       wb_sel_i,
  input  logic             wb_we_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic             wb_ack_o,
  // Card side
  output logic             sd_clk_o,
  input  logic             sd_cmd_i,
  output logic             sd_cmd_o,
  output logic             sd_cmd_oe_o,
  // Interrupts
  output logic             int_a_o,  // Normal
  output logic             int_b_o   // Error
);

  cmd_req_t    cmd_req;
  logic        cmd_launch;
  line_req_t   line_req;
  logic        line_valid;
  logic        line_accept;
  line_rsp_t   line_rsp;
  logic        line_done;
  cmd_result_t result;
  logic        result_done;
  logic [7:0]  clk_div;

  sd_wb_regs u_regs (
    .wb_clk_i, .arst_n_i,
    .wb_adr_i, .wb_dat_i, .wb_sel_i, .wb_we_i, .wb_cyc_i, .wb_stb_i,
    .wb_dat_o, .wb_ack_o,
    .cmd_req_o     (cmd_req),
    .cmd_launch_o  (cmd_launch),
    .result_i      (result),
    .result_done_i (result_done),
    .clk_div_o     (clk_div),
    .int_a_o, .int_b_o
  );

  sd_cmd_ctrl u_ctrl (
    .wb_clk_i, .arst_n_i,
    .cmd_req_i     (cmd_req),
    .cmd_launch_i  (cmd_launch),
    .line_req_o    (line_req),
    .line_valid_o  (line_valid),
    .line_accept_i (line_accept),
    .line_rsp_i    (line_rsp),
    .line_done_i   (line_done),
    .result_o      (result),
    .result_done_o (result_done)
  );

  sd_cmd_phy u_phy (
    .wb_clk_i, .arst_n_i,
    .clk_div_i     (clk_div),
    .line_req_i    (line_req),
    .line_valid_i  (line_valid),
    .line_accept_o (line_accept),
    .line_rsp_o    (line_rsp),
    .line_done_o   (line_done),
    .sd_clk_o, .sd_cmd_i, .sd_cmd_o, .sd_cmd_oe_o
  );

endmodule

// ==== design/sd_pkg.sv ====
package sd_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int WB_DW       = 32;
  localparam int WB_AW       = 8;
  localparam int CMD_TOKEN_W = 48;                        // Full token on the line
  localparam int CMD_IDX_W   = 6;
  localparam int CRC7_W      = 7;
  localparam int CMD_BODY_W  = CMD_TOKEN_W - CRC7_W - 1;  // Start bit up to argument, 40

  // Register byte offsets
  localparam logic [WB_AW-1:0] REG_ARG        = 8'h00;
  localparam logic [WB_AW-1:0] REG_CMD_SET    = 8'h04;  // Write launches a command
  localparam logic [WB_AW-1:0] REG_STATUS     = 8'h08;  // Bit 0 busy
  localparam logic [WB_AW-1:0] REG_RESP       = 8'h0C;
  localparam logic [WB_AW-1:0] REG_TIMEOUT    = 8'h10;
  localparam logic [WB_AW-1:0] REG_NORMAL_ISR = 8'h14;
  localparam logic [WB_AW-1:0] REG_ERROR_ISR  = 8'h18;
  localparam logic [WB_AW-1:0] REG_NORMAL_ISE = 8'h1C;
  localparam logic [WB_AW-1:0] REG_ERROR_ISE  = 8'h20;
  localparam logic [WB_AW-1:0] REG_CLK_DIV    = 8'h24;

  // Command setting fields
  localparam int CMDSET_RSP_LSB = 0;  // 2 bits
  localparam int CMDSET_CRC_CHK = 3;
  localparam int CMDSET_IDX_CHK = 4;
  localparam int CMDSET_IDX_LSB = 8;  // 6 bits

  // Interrupt status bits
  localparam int NISR_CMD_DONE = 0;
  localparam int NISR_ERR_SUM  = 15;
  localparam int EISR_TIMEOUT  = 0;
  localparam int EISR_CRC      = 1;
  localparam int EISR_INDEX    = 2;

  typedef enum logic [1:0] {
    RSP_NONE = 2'd0,
    RSP_48   = 2'd1   // Codes 2 and 3 behave the same
  } rsp_kind_e;

  typedef enum logic [2:0] {
    IDLE,
    SEND,
    WAIT_START,
    RECV,
    DONE
  } phy_state_e;

  //////////////////////////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [31:0]          arg;
    logic [CMD_IDX_W-1:0] index;
    rsp_kind_e            rsp;
    logic                 crc_chk;
    logic                 idx_chk;
    logic [15:0]          timeout;
  } cmd_req_t;

  typedef struct packed {
    logic [CMD_BODY_W-1:0] token;  // No CRC, no end bit
    logic                  expect_rsp;
    logic [15:0]           timeout;
  } line_req_t;

  typedef struct packed {
    logic [CMD_TOKEN_W-1:0] token;
    logic                   timed_out;
    logic                   crc_ok;
  } line_rsp_t;

  typedef struct packed {
    logic [31:0] resp_arg;
    logic        done;
    logic        timeout_err;
    logic        crc_err;
    logic        index_err;
  } cmd_result_t;

  // One serial step of CRC7, x^7 + x^3 + 1
  function automatic logic [CRC7_W-1:0] crc7_next(input logic [CRC7_W-1:0] crc,
                                                  input logic bit_i);
    logic fb;
    fb = crc[CRC7_W-1] ^ bit_i;
    return {crc[CRC7_W-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

endpackage

// ==== design/sd_wb_regs.sv ====
module sd_wb_regs import sd_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             arst_n_i,
  input  logic [WB_AW-1:0] wb_adr_i,
  input  logic [WB_DW-1:0] wb_dat_i,
  input  logic [3:0]       wb_sel_i,
  input  logic             wb_we_i,
  input  logic             wb_cyc_i,
  input  logic             wb_stb_i,
  output logic [WB_DW-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output cmd_req_t         cmd_req_o,
  output logic             cmd_launch_o,
  input  cmd_result_t      result_i,
  input  logic             result_done_i,
  output logic [7:0]       clk_div_o,
  output logic             int_a_o,
  output logic             int_b_o
);

  logic [WB_DW-1:0] arg_q;
  logic [15:0]      cmd_set_q;
  logic             busy_q;     // Status bit 0
  logic [WB_DW-1:0] resp_q;
  logic [15:0]      timeout_q;
  logic [15:0]      nisr_q, eisr_q;
  logic [15:0]      nise_q, eise_q;
  logic [7:0]       clk_div_q;

  logic             wb_req;     // New classic cycle, not yet acked
  logic             wr_en;
  logic [WB_DW-1:0] be_mask;    // Byte selects spread to bits
  logic [WB_DW-1:0] rd_data;

  assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en   = wb_req & wb_we_i;
  assign be_mask = {{8{wb_sel_i[3]}}, {8{wb_sel_i[2]}}, {8{wb_sel_i[1]}}, {8{wb_sel_i[0]}}};

  ////////////////////////////////////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    case (wb_adr_i)
      REG_ARG:        rd_data = arg_q;
      REG_CMD_SET:    rd_data[15:0] = cmd_set_q;
      REG_STATUS:     rd_data[0] = busy_q;
      REG_RESP:       rd_data = resp_q;
      REG_TIMEOUT:    rd_data[15:0] = timeout_q;
      REG_NORMAL_ISR: rd_data[15:0] = nisr_q;
      REG_ERROR_ISR:  rd_data[15:0] = eisr_q;
      REG_NORMAL_ISE: rd_data[15:0] = nise_q;
      REG_ERROR_ISE:  rd_data[15:0] = eise_q;
      REG_CLK_DIV:    rd_data[7:0] = clk_div_q;
      default:        rd_data = '0;  // Unmapped reads as zero
    endcase
  end

  always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_ack_o     <= 1'b0;
      wb_dat_o     <= '0;
      arg_q        <= '0;
      cmd_set_q    <= '0;
      busy_q       <= 1'b0;
      resp_q       <= '0;
      timeout_q    <= '0;
      nisr_q       <= '0;
      eisr_q       <= '0;
      nise_q       <= '0;
      eise_q       <= '0;
      clk_div_q    <= '0;
      cmd_launch_o <= 1'b0;
    end else begin
      wb_ack_o     <= wb_req;               // Single-cycle ack
      cmd_launch_o <= 1'b0;
      if (wb_req && !wb_we_i) wb_dat_o <= rd_data;

      if (wr_en) begin
        case (wb_adr_i)
          REG_ARG:     arg_q <= (arg_q & ~be_mask) | (wb_dat_i & be_mask);
          REG_CMD_SET: begin
            if (!busy_q) begin                // Refused while a command runs
              cmd_set_q    <= (cmd_set_q & ~be_mask[15:0]) | (wb_dat_i[15:0] & be_mask[15:0]);
              cmd_launch_o <= 1'b1;
              busy_q       <= 1'b1;
            end
          end
          REG_TIMEOUT: timeout_q <= (timeout_q & ~be_mask[15:0]) | (wb_dat_i[15:0] & be_mask[15:0]);
          REG_NORMAL_ISR: nisr_q <= '0;       // Any write clears
          REG_ERROR_ISR:  eisr_q <= '0;
          REG_NORMAL_ISE: nise_q <= (nise_q & ~be_mask[15:0]) | (wb_dat_i[15:0] & be_mask[15:0]);
          REG_ERROR_ISE:  eise_q <= (eise_q & ~be_mask[15:0]) | (wb_dat_i[15:0] & be_mask[15:0]);
          REG_CLK_DIV: clk_div_q <= (clk_div_q & ~be_mask[7:0]) | (wb_dat_i[7:0] & be_mask[7:0]);
          default: ;
        endcase
      end

      // Result wins over a clear on the same edge
      if (result_done_i) begin
        busy_q <= 1'b0;
        resp_q <= result_i.resp_arg;
        if (result_i.done)        nisr_q[NISR_CMD_DONE] <= 1'b1;
        if (result_i.timeout_err) eisr_q[EISR_TIMEOUT]  <= 1'b1;
        if (result_i.crc_err)     eisr_q[EISR_CRC]      <= 1'b1;
        if (result_i.index_err)   eisr_q[EISR_INDEX]    <= 1'b1;
        if (result_i.timeout_err || result_i.crc_err || result_i.index_err) begin
          nisr_q[NISR_ERR_SUM] <= 1'b1;       // Error summary
        end
      end
    end
  end

  // Request fields taken straight from the registers
  assign cmd_req_o = '{
    arg:     arg_q,
    index:   cmd_set_q[CMDSET_IDX_LSB +: CMD_IDX_W],
    rsp:     rsp_kind_e'(cmd_set_q[CMDSET_RSP_LSB +: 2]),
    crc_chk: cmd_set_q[CMDSET_CRC_CHK],
    idx_chk: cmd_set_q[CMDSET_IDX_CHK],
    timeout: timeout_q
  };

  assign clk_div_o = clk_div_q;
  assign int_a_o   = |(nisr_q & nise_q);
  assign int_b_o   = |(eisr_q & eise_q);

  // Master must hold stb until it sees ack
  a_ack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
    wb_ack_o |-> wb_stb_i)
    else $error("wb ack without strobe");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the SD command controller testbench with Verilator, run it, check the log
set -eo pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f build.f --top-module tb_sd_ctrl -o tb_sd_ctrl

./obj_dir/tb_sd_ctrl | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "Simulation PASS"
  exit 0
else
  echo "Simulation FAIL"
  exit 1
fi

// ==== test/tb_sd_card_model.sv ====
module tb_sd_card_model (
  input  logic        sd_clk_i,      // SD clock from the host
  input  logic        cmd_i,         // Host CMD drive
  input  logic        cmd_oe_i,
  output logic        cmd_o,         // Card CMD drive, idles high
  input  logic [1:0]  reply_mode_i,  // 0 answer, 1 silent, 2 corrupt CRC
  input  logic [5:0]  reply_idx_i,
  input  logic [31:0] reply_arg_i,
  input  logic [7:0]  reply_gap_i,   // SD clocks from command end to reply
  output int          cmd_count_o,
  output logic [5:0]  last_idx_o,
  output logic [31:0] last_arg_o,
  output int          bad_cmd_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] REPLY_SILENT  = 2'd1;
  localparam logic [1:0] REPLY_BAD_CRC = 2'd2;

  logic [47:0] cmd_tok;  // Command as seen on the line

  // Remainder of body * x^7 over x^7 + x^3 + 1
  function automatic logic [6:0] crc7_of(input logic [39:0] body);
    logic [46:0] rem;
    rem = {body, 7'd0};
    for (int i = 46; i >= 7; i--) begin
      if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ 8'h89;
    end
    return rem[6:0];
  endfunction

  task automatic send_reply();
    logic [47:0] rsp;
    rsp        = '0;           // Start and transmission bits 0
    rsp[45:40] = reply_idx_i;
    rsp[39:8]  = reply_arg_i;
    rsp[7:1]   = crc7_of(rsp[47:8]);
    if (reply_mode_i == REPLY_BAD_CRC) rsp[7:1] = ~rsp[7:1];
    rsp[0]     = 1'b1;         // End bit
    repeat (reply_gap_i) @(negedge sd_clk_i);
    for (int b = 47; b >= 0; b--) begin
      @(negedge sd_clk_i);
      cmd_o <= rsp[b];         // Change on falling edge
    end
  endtask

  initial begin
    cmd_o       <= 1'b1;
    cmd_count_o = 0;
    bad_cmd_o   = 0;
    last_idx_o  = '0;
    last_arg_o  = '0;
    cmd_tok     = '0;
    forever begin
      @(posedge sd_clk_i);
      if (cmd_oe_i && !cmd_i) begin          // Start bit from host
        cmd_tok = '0;
        for (int b = 46; b >= 0; b--) begin
          @(posedge sd_clk_i);
          cmd_tok[b] = cmd_i;
        end
        if (!cmd_tok[46] || !cmd_tok[0] || cmd_tok[7:1] != crc7_of(cmd_tok[47:8])) begin
          bad_cmd_o++;
          $display("Card model at %0t: command token %h has a bad CRC7 or framing",
                   $time, cmd_tok);
        end
        cmd_count_o++;
        last_idx_o = cmd_tok[45:40];
        last_arg_o = cmd_tok[39:8];
        if (reply_mode_i != REPLY_SILENT) send_reply();
      end
    end
  end

endmodule

// ==== test/tb_sd_ctrl.sv ====
module tb_sd_ctrl import sd_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ENTRIES = 9;
  localparam int ACK_LIMIT   = 16;     // Cycles for one bus ack
  localparam int POLL_LIMIT  = 1000;   // STATUS reads per command
  localparam int CLK_LIMIT   = 600;    // Wb clocks to wait for one sd_clk_o toggle
  localparam int WATCHDOG_NS = (16 + NUM_ENTRIES * 2000) * 8;

  localparam logic [1:0] REPLY_OK      = 2'd0;
  localparam logic [1:0] REPLY_SILENT  = 2'd1;
  localparam logic [1:0] REPLY_BAD_CRC = 2'd2;

  typedef struct packed {
    logic [5:0]  idx;
    logic [1:0]  rsp;
    logic        crc_chk;
    logic        idx_chk;
    logic [1:0]  reply_mode;
    logic [5:0]  reply_idx;
    logic [7:0]  clk_div;
    logic [15:0] timeout;
    logic [15:0] nise;
    logic [15:0] eise;
    logic        busy_write;  // Second CMD_SET while busy
    logic        chk_resp;
    logic [15:0] exp_nisr;
    logic [15:0] exp_eisr;
    logic        exp_int_a;
    logic        exp_int_b;
  } entry_t;

  logic             wb_clk_i = 1'b0;
  logic             arst_n_i;
  logic [WB_AW-1:0] wb_adr_i;
  logic [WB_DW-1:0] wb_dat_i;
  logic [WB_DW-1:0] wb_dat_o;
  logic [3:0]       wb_sel_i;
  logic             wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
  logic             sd_clk_o, sd_cmd_i, sd_cmd_o, sd_cmd_oe_o;
  logic             int_a_o, int_b_o;

  logic [1:0]  card_mode;
  logic [5:0]  card_reply_idx;
  logic [31:0] card_reply_arg;
  int          card_cmds, card_bad;
  logic [5:0]  card_idx;
  logic [31:0] card_arg;

  entry_t table_q [NUM_ENTRIES];
  int     errors    = 0;
  int     cur_entry = -1;

  always #4 wb_clk_i = ~wb_clk_i;  // 8 ns period

  sd_ctrl_top dut (.*);

  tb_sd_card_model card (
    .sd_clk_i     (sd_clk_o),
    .cmd_i        (sd_cmd_o),
    .cmd_oe_i     (sd_cmd_oe_o),
    .cmd_o        (sd_cmd_i),
    .reply_mode_i (card_mode),
    .reply_idx_i  (card_reply_idx),
    .reply_arg_i  (card_reply_arg),
    .reply_gap_i  (8'd2),
    .cmd_count_o  (card_cmds),
    .last_idx_o   (card_idx),
    .last_arg_o   (card_arg),
    .bad_cmd_o    (card_bad)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////
  function automatic void load_table();
    // idx rsp crc_chk idx_chk reply reply_idx div timeout
    // nise eise busy_write chk_resp exp_nisr exp_eisr int_a int_b
    table_q[0] = '{6'd0, 2'd0, 1'b0, 1'b0, REPLY_SILENT, 6'd0, 8'd0, 16'd64,    // No response
                   16'h0001, 16'h0000, 1'b0, 1'b0, 16'h0001, 16'h0000, 1'b1, 1'b0};
    table_q[1] = '{6'd8, 2'd1, 1'b1, 1'b1, REPLY_OK, 6'd8, 8'd0, 16'd64,        // Busy refusal
                   16'h0001, 16'h0007, 1'b1, 1'b1, 16'h0001, 16'h0000, 1'b1, 1'b0};
    table_q[2] = '{6'd17, 2'd1, 1'b1, 1'b1, REPLY_OK, 6'd17, 8'd1, 16'd64,      // Enables off
                   16'h0000, 16'h0007, 1'b0, 1'b1, 16'h0001, 16'h0000, 1'b0, 1'b0};
    table_q[3] = '{6'd55, 2'd1, 1'b1, 1'b1, REPLY_OK, 6'd55, 8'd3, 16'd64,
                   16'h8001, 16'h0007, 1'b0, 1'b1, 16'h0001, 16'h0000, 1'b1, 1'b0};
    table_q[4] = '{6'd13, 2'd1, 1'b1, 1'b1, REPLY_SILENT, 6'd0, 8'd1, 16'd20,   // Timeout
                   16'h8000, 16'h0001, 1'b0, 1'b0, 16'h8001, 16'h0001, 1'b1, 1'b1};
    table_q[5] = '{6'd12, 2'd1, 1'b1, 1'b1, REPLY_BAD_CRC, 6'd12, 8'd0, 16'd64,
                   16'h0001, 16'h0002, 1'b0, 1'b1, 16'h8001, 16'h0002, 1'b1, 1'b1};
    table_q[6] = '{6'd12, 2'd2, 1'b0, 1'b1, REPLY_BAD_CRC, 6'd12, 8'd2, 16'd64, // CRC check off
                   16'h0001, 16'h0007, 1'b0, 1'b1, 16'h0001, 16'h0000, 1'b1, 1'b0};
    table_q[7] = '{6'd41, 2'd3, 1'b1, 1'b1, REPLY_OK, 6'd9, 8'd1, 16'd64,       // Wrong index
                   16'h0001, 16'h0003, 1'b0, 1'b1, 16'h8001, 16'h0004, 1'b1, 1'b0};
    table_q[8] = '{6'd41, 2'd1, 1'b1, 1'b0, REPLY_OK, 6'd9, 8'd0, 16'd64,
                   16'h0001, 16'h0004, 1'b0, 1'b1, 16'h0001, 16'h0000, 1'b1, 1'b0};
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: entry %0d %s got %h expected %h",
               $time, cur_entry, what, got, exp);
    end
  endtask

  // One Wishbone classic cycle ending on the edge that sees ack
  task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [WB_DW-1:0] dat, output logic [WB_DW-1:0] rdat);
    int waits;
    waits = 0;
    @(posedge wb_clk_i);
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= 4'hF;
    wb_we_i  <= we;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    do begin
      @(posedge wb_clk_i);
      waits++;
    end while (!wb_ack_o && waits < ACK_LIMIT);
    rdat = wb_dat_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!wb_ack_o) begin
      errors++;
      $display("No Wishbone ack for address %h within %0d cycles", adr, ACK_LIMIT);
    end
  endtask

  task automatic write_reg(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] dat);
    logic [WB_DW-1:0] ignored;
    bus_cycle(1'b1, adr, dat, ignored);
  endtask

  task automatic read_reg(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] dat);
    bus_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          polls;
    polls = 0;
    st    = 32'h1;
    while (st[0] && polls < POLL_LIMIT) begin
      read_reg(REG_STATUS, st);
      polls++;
    end
    if (st[0]) begin
      errors++;
      $display("STATUS busy still set after %0d polls in entry %0d", polls, cur_entry);
    end
  endtask

  // Counts wb clocks between two sd_clk_o toggles
  task automatic check_sd_clk(input logic [7:0] div);
    logic level;
    int   cycles;
    @(posedge wb_clk_i);
    level  = sd_clk_o;
    cycles = 0;
    while (sd_clk_o == level && cycles < CLK_LIMIT) begin  // Align to a toggle
      @(posedge wb_clk_i);
      cycles++;
    end
    level  = sd_clk_o;
    cycles = 0;
    while (sd_clk_o == level && cycles < CLK_LIMIT) begin
      @(posedge wb_clk_i);
      cycles++;
    end
    check_value("sd_clk_o half period", 32'(cycles), 32'(div) + 32'd1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // One table entry from launch to ISR clear
  //////////////////////////////////////////////////////////////////////
  task automatic run_entry(input entry_t e);
    logic [31:0] arg, reply_arg, word, rd;
    int          cmds_before;
    arg         = $urandom();
    reply_arg   = $urandom();
    word        = 32'({e.idx, 3'b000, e.idx_chk, e.crc_chk, 1'b0, e.rsp});  // Index at 13:8
    cmds_before = card_cmds;
    card_mode      <= e.reply_mode;
    card_reply_idx <= e.reply_idx;
    card_reply_arg <= reply_arg;
    write_reg(REG_CLK_DIV, 32'(e.clk_div));
    check_sd_clk(e.clk_div);
    write_reg(REG_TIMEOUT, 32'(e.timeout));
    write_reg(REG_NORMAL_ISE, 32'(e.nise));
    write_reg(REG_ERROR_ISE, 32'(e.eise));
    write_reg(REG_ARG, arg);
    write_reg(REG_CMD_SET, word);
    read_reg(REG_STATUS, rd);
    check_value("STATUS right after launch", rd, 32'h1);
    if (e.busy_write) begin
      write_reg(REG_CMD_SET, {18'd0, ~e.idx, 8'h00});  // Should be refused
      read_reg(REG_CMD_SET, rd);
      check_value("CMD_SET after write while busy", rd, word);
    end
    wait_idle();
    read_reg(REG_RESP, rd);
    if (e.chk_resp) check_value("RESP", rd, reply_arg);
    read_reg(REG_NORMAL_ISR, rd);
    check_value("NORMAL_ISR", rd, 32'(e.exp_nisr));
    read_reg(REG_ERROR_ISR, rd);
    check_value("ERROR_ISR", rd, 32'(e.exp_eisr));
    check_value("int_a_o", 32'(int_a_o), 32'(e.exp_int_a));
    check_value("int_b_o", 32'(int_b_o), 32'(e.exp_int_b));
    check_value("commands seen by card", 32'(card_cmds - cmds_before), 32'd1);
    check_value("card index", 32'(card_idx), 32'(e.idx));
    check_value("card argument", card_arg, arg);
    // Any write clears an ISR, even one of all zeros
    write_reg(REG_NORMAL_ISR, 32'h0000_0000);
    write_reg(REG_ERROR_ISR, 32'h0000_0000);
    read_reg(REG_NORMAL_ISR, rd);
    check_value("NORMAL_ISR after clear", rd, 32'd0);
    read_reg(REG_ERROR_ISR, rd);
    check_value("ERROR_ISR after clear", rd, 32'd0);
    check_value("int_a_o after clear", 32'(int_a_o), 32'd0);
    check_value("int_b_o after clear", 32'(int_b_o), 32'd0);
  endtask

  initial begin
    void'($urandom(49723));
    arst_n_i       <= 1'b0;
    wb_adr_i       <= '0;
    wb_dat_i       <= '0;
    wb_sel_i       <= 4'h0;
    wb_we_i        <= 1'b0;
    wb_cyc_i       <= 1'b0;
    wb_stb_i       <= 1'b0;
    card_mode      <= REPLY_SILENT;
    card_reply_idx <= '0;
    card_reply_arg <= '0;
    load_table();
    repeat (16) @(posedge wb_clk_i);
    check_value("sd_cmd_o after reset", 32'(sd_cmd_o), 32'd1);
    check_value("sd_cmd_oe_o after reset", 32'(sd_cmd_oe_o), 32'd0);
    check_value("wb_ack_o after reset", 32'(wb_ack_o), 32'd0);
    check_value("interrupts after reset", 32'({int_a_o, int_b_o}), 32'd0);
    arst_n_i <= 1'b1;
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      cur_entry = n;
      run_entry(table_q[n]);
    end
    $display("Ran %0d entries: %0d check errors, %0d bad commands at the card",
             NUM_ENTRIES, errors, card_bad);
    if (errors == 0 && card_bad == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns in entry %0d", WATCHDOG_NS, cur_entry);
    $display("tests failed");
    $finish;
  end

endmodule
